/* cmd_dispatcher.sv */
// Command FIFO data is taken on the read edge; write FIFO data is valid the cycle after its read
`timescale 1ns/1ns

module cmd_dispatcher (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  dispatch_pkg::cmd_word_t  i_cmd_fifo_data,
    input  logic                     i_cmd_fifo_empty,
    output logic                     o_cmd_fifo_re,
    input  dispatch_pkg::data_word_t i_wr_fifo_data,
    input  dispatch_pkg::fifo_count_t i_wr_fifo_count,
    output logic                     o_wr_fifo_re,
    input  dispatch_pkg::bus_mask_t  i_bus_cmd_ack,
    input  dispatch_pkg::chip_mask_t i_bus_chip_active,
    input  dispatch_pkg::bus_mask_t  i_bus_wr_buffer_rsvd,
    input  dispatch_pkg::bus_mask_t  i_bus_rd_buffer_rsvd,
    output dispatch_pkg::bus_mask_t  o_bus_cmd_req,
    output dispatch_pkg::cmd_word_t  o_bus_cmd_data,
    output dispatch_pkg::buf_addr_t  o_bus_wr_buffer_addr,
    output dispatch_pkg::data_word_t o_bus_wr_buffer_data,
    output dispatch_pkg::bus_mask_t  o_bus_wr_buffer_we,
    output logic                     o_tag_we,
    output dispatch_pkg::tag_t       o_tag,
    output logic                     o_tag_is_read
);
    import dispatch_pkg::*;

    cmd_state_e  state_q, state_d;
    cmd_word_t   cmd_q;
    bus_mask_t   req_q, req_d;
    buf_addr_t   wr_addr_q, wr_addr_d;
    fifo_count_t fill_cnt_q, fill_cnt_d;
    logic        wr_re_q, wr_re_d;
    logic        tag_we_q;

    size_t                 size;
    opcode_t               opcode;
    bus_addr_t             bus_addr;
    logic [BUS_NUM_W-1:0]  bus_num;
    logic [CHIP_NUM_W-1:0] chip_num;
    bus_mask_t             bus_mask;
    chip_mask_t            chip_mask;
    logic                  is_read;
    logic                  is_program;

    // Fields of the latched command
    assign size     = cmd_q[CMD_SIZE_LSB +: SIZE_W];
    assign opcode   = cmd_q[CMD_OP_LSB +: OP_W];
    assign bus_addr = cmd_q[ADDR_W-1:0];
    assign bus_num  = bus_addr[BUS_NUM_LSB +: BUS_NUM_W];
    assign chip_num = bus_addr[CHIP_NUM_LSB +: CHIP_NUM_W];

    assign bus_mask   = bus_mask_t'(1) << bus_num;
    assign chip_mask  = chip_mask_t'(1) << (bus_num * CHIPS_PER_BUS + chip_num);
    assign is_read    = (opcode == HOP_READ);
    assign is_program = (opcode == HOP_PROGRAM);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q    <= IDLE;
            req_q      <= '0;
            wr_addr_q  <= '0;
            fill_cnt_q <= '0;
            wr_re_q    <= 1'b0;
            tag_we_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            req_q      <= req_d;
            wr_addr_q  <= wr_addr_d;
            fill_cnt_q <= fill_cnt_d;
            wr_re_q    <= wr_re_d;
            // Tag table write on entry to SEND_REQ
            tag_we_q   <= (state_d == SEND_REQ) && (state_q != SEND_REQ);
        end
    end

    // Command held steady from FIFO read until the next one
    always_ff @(posedge i_clk) begin
        if (state_q == IDLE && !i_cmd_fifo_empty) begin
            cmd_q <= i_cmd_fifo_data;
        end
    end

    always_comb begin
        state_d            = state_q;
        req_d              = req_q;
        wr_addr_d          = wr_addr_q;
        fill_cnt_d         = fill_cnt_q;
        wr_re_d            = 1'b0;
        o_bus_wr_buffer_we = '0;

        unique case (state_q)
            IDLE: begin
                if (!i_cmd_fifo_empty) begin
                    state_d = WAIT_CHIP;
                end
            end

            WAIT_CHIP: begin
                if ((i_bus_chip_active & chip_mask) == '0) begin
                    if (is_program) begin
                        state_d = WAIT_WR_BUF;
                    end else if (is_read) begin
                        state_d = WAIT_RD_BUF;
                    end else begin
                        state_d = SEND_REQ;
                    end
                end
            end

            WAIT_WR_BUF: begin
                // Size counts 256-bit units, two words each
                fill_cnt_d = {size, 1'b0};
                wr_addr_d  = '0;
                if (!i_bus_wr_buffer_rsvd[bus_num]) begin
                    state_d = FILL_WAIT;
                end
            end

            WAIT_RD_BUF: begin
                if (!i_bus_rd_buffer_rsvd[bus_num]) begin
                    state_d = SEND_REQ;
                end
            end

            FILL_WAIT: begin
                if (i_wr_fifo_count >= fill_cnt_q) begin
                    wr_re_d = 1'b1;
                    state_d = FILL;
                end
            end

            FILL: begin
                // Strobe cycle, then the data cycle
                if (!wr_re_q) begin
                    o_bus_wr_buffer_we = bus_mask;
                    wr_addr_d          = wr_addr_q + 1'b1;
                    fill_cnt_d         = fill_cnt_q - 1'b1;
                    if (fill_cnt_q == fifo_count_t'(1)) begin
                        req_d   = bus_mask;
                        state_d = SEND_REQ;
                    end else begin
                        wr_re_d = 1'b1;
                    end
                end
            end

            SEND_REQ: begin
                req_d = bus_mask;
                if (|i_bus_cmd_ack) begin
                    req_d   = '0;
                    state_d = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    // Read strobe in the same cycle as the command latch
    assign o_cmd_fifo_re        = (state_q == IDLE) && !i_cmd_fifo_empty;
    assign o_wr_fifo_re         = wr_re_q;
    assign o_bus_cmd_req        = req_q;
    assign o_bus_cmd_data       = cmd_q;
    assign o_bus_wr_buffer_addr = wr_addr_q;
    assign o_bus_wr_buffer_data = i_wr_fifo_data;
    assign o_tag_we             = tag_we_q;
    assign o_tag                = cmd_q[CMD_TAG_LSB +: TAG_W];
    assign o_tag_is_read        = is_read;

endmodule

/* dispatch_pkg.sv */
// Fixed widths for four buses of four chips; only read, program and erase opcodes are decoded
package dispatch_pkg;

    localparam int NUM_BUSES         = 4;
    localparam int CHIPS_PER_BUS     = 4;
    localparam int NUM_CHIPS         = NUM_BUSES * CHIPS_PER_BUS;
    localparam int MAX_RD_FIFO_WORDS = 1024;

    // Bus read buffer delay from address to data
    localparam int RD_BUF_LATENCY = 2;

    localparam int TAG_W      = 8;
    localparam int SIZE_W     = 10;
    localparam int OP_W       = 8;
    localparam int ADDR_W     = 46;
    localparam int ERR_W      = 8;
    localparam int CMD_W      = TAG_W + SIZE_W + OP_W + ADDR_W;
    localparam int RSLT_W     = TAG_W + SIZE_W + ERR_W;
    localparam int DATA_W     = 128;
    localparam int BUF_ADDR_W = 10;
    localparam int FIFO_CNT_W = 11;

    // Command word is {tag, size, opcode, bus address}
    localparam int CMD_TAG_LSB  = CMD_W - TAG_W;
    localparam int CMD_SIZE_LSB = CMD_TAG_LSB - SIZE_W;
    localparam int CMD_OP_LSB   = CMD_SIZE_LSB - OP_W;

    // Bus number on top, then two spare bits, then the chip number
    localparam int BUS_NUM_W    = $clog2(NUM_BUSES);
    localparam int CHIP_NUM_W   = $clog2(CHIPS_PER_BUS);
    localparam int BUS_NUM_LSB  = ADDR_W - BUS_NUM_W;
    localparam int CHIP_NUM_LSB = BUS_NUM_LSB - 2 - CHIP_NUM_W;

    // Result word is {tag, size, error}
    localparam int RSLT_TAG_LSB  = RSLT_W - TAG_W;
    localparam int RSLT_SIZE_LSB = ERR_W;

    typedef logic [CMD_W-1:0]      cmd_word_t;
    typedef logic [ADDR_W-1:0]     bus_addr_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [SIZE_W-1:0]     size_t;
    typedef logic [OP_W-1:0]       opcode_t;
    typedef logic [RSLT_W-1:0]     rslt_word_t;
    typedef logic [DATA_W-1:0]     data_word_t;
    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_count_t;
    typedef logic [NUM_BUSES-1:0]  bus_mask_t;
    typedef logic [NUM_CHIPS-1:0]  chip_mask_t;

    localparam opcode_t HOP_READ    = 8'h01;
    localparam opcode_t HOP_PROGRAM = 8'h02;
    localparam opcode_t HOP_ERASE   = 8'h03;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_CHIP,
        WAIT_WR_BUF,
        WAIT_RD_BUF,
        FILL_WAIT,
        FILL,
        SEND_REQ
    } cmd_state_e;

    typedef enum logic [2:0] {
        POLL,
        CHECK,
        DRAIN_WAIT,
        DRAIN_LEAD,
        DRAIN,
        SEND_RSLT
    } rslt_state_e;

endpackage

/* filelist.f */
dispatch_pkg.sv
cmd_dispatcher.sv
tag_rnw_table.sv
rslt_collector.sv
flash_bus_dispatch.sv
tb_flash_bus_dispatch.sv

/* flash_bus_dispatch.sv */
// Host FIFOs are standard FIFOs; bus buffers are shared by address and selected by write enable
`timescale 1ns/1ns

module flash_bus_dispatch (
    input  logic                      i_clk,
    input  logic                      i_rst,

    // Command FIFO
    input  dispatch_pkg::cmd_word_t   i_cmd_fifo_data,
    output logic                      o_cmd_fifo_re,
    input  logic                      i_cmd_fifo_empty,

    // Write FIFO
    input  dispatch_pkg::data_word_t  i_wr_fifo_data,
    output logic                      o_wr_fifo_re,
    input  dispatch_pkg::fifo_count_t i_wr_fifo_count,

    // Read FIFO
    output dispatch_pkg::data_word_t  o_rd_fifo_data,
    output logic                      o_rd_fifo_we,
    input  dispatch_pkg::fifo_count_t i_rd_fifo_count,

    // Result FIFO
    output dispatch_pkg::rslt_word_t  o_rslt_fifo_data,
    output logic                      o_rslt_fifo_we,
    input  logic                      i_rslt_fifo_full,

    // Flash buses
    output dispatch_pkg::bus_mask_t   o_bus_cmd_req,
    input  dispatch_pkg::bus_mask_t   i_bus_cmd_ack,
    output dispatch_pkg::cmd_word_t   o_bus_cmd_data,
    input  dispatch_pkg::bus_mask_t   i_bus_rsp_req,
    output dispatch_pkg::bus_mask_t   o_bus_rsp_ack,
    output dispatch_pkg::bus_mask_t   o_bus_rsp_listening,
    input  dispatch_pkg::rslt_word_t  i_bus_rsp_data,
    input  dispatch_pkg::chip_mask_t  i_bus_chip_active,
    input  dispatch_pkg::bus_mask_t   i_bus_wr_buffer_rsvd,
    input  dispatch_pkg::bus_mask_t   i_bus_rd_buffer_rsvd,

    // Bus buffers
    output dispatch_pkg::buf_addr_t   o_bus_wr_buffer_addr,
    output dispatch_pkg::data_word_t  o_bus_wr_buffer_data,
    output dispatch_pkg::bus_mask_t   o_bus_wr_buffer_we,
    output dispatch_pkg::buf_addr_t   o_bus_rd_buffer_addr,
    input  dispatch_pkg::data_word_t  i_bus_rd_buffer_data
);
    import dispatch_pkg::*;

    // Tag table links
    logic tag_we;
    tag_t tag_wr;
    logic tag_wr_is_read;
    tag_t tag_rd;
    logic tag_rd_is_read;

    cmd_dispatcher cmd_i (
        .i_clk                (i_clk),
        .i_rst                (i_rst),
        .i_cmd_fifo_data      (i_cmd_fifo_data),
        .i_cmd_fifo_empty     (i_cmd_fifo_empty),
        .o_cmd_fifo_re        (o_cmd_fifo_re),
        .i_wr_fifo_data       (i_wr_fifo_data),
        .i_wr_fifo_count      (i_wr_fifo_count),
        .o_wr_fifo_re         (o_wr_fifo_re),
        .i_bus_cmd_ack        (i_bus_cmd_ack),
        .i_bus_chip_active    (i_bus_chip_active),
        .i_bus_wr_buffer_rsvd (i_bus_wr_buffer_rsvd),
        .i_bus_rd_buffer_rsvd (i_bus_rd_buffer_rsvd),
        .o_bus_cmd_req        (o_bus_cmd_req),
        .o_bus_cmd_data       (o_bus_cmd_data),
        .o_bus_wr_buffer_addr (o_bus_wr_buffer_addr),
        .o_bus_wr_buffer_data (o_bus_wr_buffer_data),
        .o_bus_wr_buffer_we   (o_bus_wr_buffer_we),
        .o_tag_we             (tag_we),
        .o_tag                (tag_wr),
        .o_tag_is_read        (tag_wr_is_read)
    );

    tag_rnw_table tag_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_we         (tag_we),
        .i_wr_tag     (tag_wr),
        .i_is_read    (tag_wr_is_read),
        .i_rd_tag     (tag_rd),
        .o_rd_is_read (tag_rd_is_read)
    );

    rslt_collector rslt_i (
        .i_clk                (i_clk),
        .i_rst                (i_rst),
        .i_bus_rsp_req        (i_bus_rsp_req),
        .i_bus_rsp_data       (i_bus_rsp_data),
        .i_rd_fifo_count      (i_rd_fifo_count),
        .i_rslt_fifo_full     (i_rslt_fifo_full),
        .i_bus_rd_buffer_data (i_bus_rd_buffer_data),
        .i_tag_is_read        (tag_rd_is_read),
        .o_bus_rsp_ack        (o_bus_rsp_ack),
        .o_bus_rsp_listening  (o_bus_rsp_listening),
        .o_bus_rd_buffer_addr (o_bus_rd_buffer_addr),
        .o_rd_fifo_data       (o_rd_fifo_data),
        .o_rd_fifo_we         (o_rd_fifo_we),
        .o_rslt_fifo_data     (o_rslt_fifo_data),
        .o_rslt_fifo_we       (o_rslt_fifo_we),
        .o_tag                (tag_rd)
    );

endmodule

/* rslt_collector.sv */
// Read buffer must return data two cycles after the address; one response is handled at a time
`timescale 1ns/1ns

module rslt_collector (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  dispatch_pkg::bus_mask_t   i_bus_rsp_req,
    input  dispatch_pkg::rslt_word_t  i_bus_rsp_data,
    input  dispatch_pkg::fifo_count_t i_rd_fifo_count,
    input  logic                      i_rslt_fifo_full,
    input  dispatch_pkg::data_word_t  i_bus_rd_buffer_data,
    input  logic                      i_tag_is_read,
    output dispatch_pkg::bus_mask_t   o_bus_rsp_ack,
    output dispatch_pkg::bus_mask_t   o_bus_rsp_listening,
    output dispatch_pkg::buf_addr_t   o_bus_rd_buffer_addr,
    output dispatch_pkg::data_word_t  o_rd_fifo_data,
    output logic                      o_rd_fifo_we,
    output dispatch_pkg::rslt_word_t  o_rslt_fifo_data,
    output logic                      o_rslt_fifo_we,
    output dispatch_pkg::tag_t        o_tag
);
    import dispatch_pkg::*;

    rslt_state_e state_q, state_d;
    bus_mask_t   poll_q, poll_d;
    bus_mask_t   ack_q, ack_d;
    buf_addr_t   rd_addr_q, rd_addr_d;
    fifo_count_t drain_cnt_q, drain_cnt_d;
    logic        rd_we_q, rd_we_d;
    logic        rslt_we_q, rslt_we_d;
    rslt_word_t  rslt_q;
    data_word_t  rd_data_q;

    logic        hit;
    size_t       size;
    fifo_count_t drain_words;
    fifo_count_t rd_room;

    assign hit         = |(i_bus_rsp_req & poll_q);
    assign size        = rslt_q[RSLT_SIZE_LSB +: SIZE_W];
    assign drain_words = {size, 1'b0};
    assign rd_room     = fifo_count_t'(MAX_RD_FIFO_WORDS) - i_rd_fifo_count;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q     <= POLL;
            poll_q      <= bus_mask_t'(1);
            ack_q       <= '0;
            rd_addr_q   <= '0;
            drain_cnt_q <= '0;
            rd_we_q     <= 1'b0;
            rslt_we_q   <= 1'b0;
        end else begin
            state_q     <= state_d;
            poll_q      <= poll_d;
            ack_q       <= ack_d;
            rd_addr_q   <= rd_addr_d;
            drain_cnt_q <= drain_cnt_d;
            rd_we_q     <= rd_we_d;
            rslt_we_q   <= rslt_we_d;
        end
    end

    // Response word and read data
    always_ff @(posedge i_clk) begin
        if (state_q == POLL && hit) begin
            rslt_q <= i_bus_rsp_data;
        end
        rd_data_q <= i_bus_rd_buffer_data;
    end

    always_comb begin
        state_d     = state_q;
        poll_d      = poll_q;
        ack_d       = '0;
        rd_addr_d   = rd_addr_q;
        drain_cnt_d = drain_cnt_q;
        rd_we_d     = 1'b0;
        rslt_we_d   = 1'b0;

        unique case (state_q)
            POLL: begin
                if (hit) begin
                    ack_d   = poll_q;
                    state_d = CHECK;
                end else begin
                    poll_d = {poll_q[NUM_BUSES-2:0], poll_q[NUM_BUSES-1]};
                end
            end

            CHECK: begin
                state_d = i_tag_is_read ? DRAIN_WAIT : SEND_RSLT;
            end

            DRAIN_WAIT: begin
                rd_addr_d   = '0;
                drain_cnt_d = drain_words;
                // Whole transfer must fit before streaming starts
                if (drain_words <= rd_room) begin
                    state_d = DRAIN_LEAD;
                end
            end

            DRAIN_LEAD: begin
                // Prime the buffer pipeline
                rd_addr_d = rd_addr_q + 1'b1;
                if (rd_addr_q == buf_addr_t'(RD_BUF_LATENCY - 1)) begin
                    state_d = DRAIN;
                end
            end

            DRAIN: begin
                rd_addr_d   = rd_addr_q + 1'b1;
                rd_we_d     = 1'b1;
                drain_cnt_d = drain_cnt_q - 1'b1;
                if (drain_cnt_q == fifo_count_t'(1)) begin
                    state_d = SEND_RSLT;
                end
            end

            SEND_RSLT: begin
                if (!i_rslt_fifo_full) begin
                    rslt_we_d = 1'b1;
                    poll_d    = {poll_q[NUM_BUSES-2:0], poll_q[NUM_BUSES-1]};
                    state_d   = POLL;
                end
            end

            default: state_d = POLL;
        endcase
    end

    assign o_bus_rsp_ack        = ack_q;
    assign o_bus_rsp_listening  = poll_q;
    assign o_bus_rd_buffer_addr = rd_addr_q;
    assign o_rd_fifo_data       = rd_data_q;
    assign o_rd_fifo_we         = rd_we_q;
    assign o_rslt_fifo_data     = rslt_q;
    assign o_rslt_fifo_we       = rslt_we_q;
    assign o_tag                = rslt_q[RSLT_TAG_LSB +: TAG_W];

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator and run; success only if the pass message is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_flash_bus_dispatch -o sim_flash_bus_dispatch \
    && ./obj_dir/sim_flash_bus_dispatch | tee /dev/stderr | grep -q "^Testbench passed$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tag_rnw_table.sv */
// One flag per tag; a tag reused before its response returns overwrites the old flag
`timescale 1ns/1ns

module tag_rnw_table (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_we,
    input  dispatch_pkg::tag_t i_wr_tag,
    input  logic               i_is_read,
    input  dispatch_pkg::tag_t i_rd_tag,
    output logic               o_rd_is_read
);
    import dispatch_pkg::*;

    // Set for tags whose response carries read data
    logic [2**$bits(tag_t)-1:0] rnw_q;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            rnw_q <= '0;
        end else if (i_we) begin
            rnw_q[i_wr_tag] <= i_is_read;
        end
    end

    assign o_rd_is_read = rnw_q[i_rd_tag];

endmodule

/* tb_flash_bus_dispatch.sv */
// Rows run one at a time; bus, FIFO and read buffer models are simple and never stall the DUT
`timescale 1ns/1ns

module tb_flash_bus_dispatch;
    import dispatch_pkg::*;

    localparam int NUM_ROWS    = 10;
    localparam int HOLD_CYCLES = 80;
    localparam logic [1:0] HOLD_NONE = 2'd0;
    localparam logic [1:0] HOLD_CHIP = 2'd1;
    localparam logic [1:0] HOLD_RSLT = 2'd2;

    typedef struct packed {
        opcode_t    op;
        tag_t       tag;
        size_t      size;
        logic [1:0] bus;
        logic [1:0] chip;
        logic [1:0] hold;
    } row_t;

    // Opcode, tag, size, bus, chip, hold
    row_t rows [NUM_ROWS] = '{
        '{HOP_ERASE,   8'h10, 10'd1, 2'd0, 2'd0, HOLD_NONE},
        '{HOP_PROGRAM, 8'h21, 10'd2, 2'd1, 2'd2, HOLD_NONE},
        '{HOP_READ,    8'h32, 10'd3, 2'd2, 2'd1, HOLD_NONE},
        '{HOP_READ,    8'h43, 10'd1, 2'd3, 2'd3, HOLD_NONE},
        '{HOP_PROGRAM, 8'h54, 10'd3, 2'd0, 2'd1, HOLD_NONE},
        '{HOP_ERASE,   8'h65, 10'd2, 2'd2, 2'd3, HOLD_CHIP},
        '{HOP_READ,    8'h76, 10'd2, 2'd1, 2'd0, HOLD_RSLT},
        '{HOP_PROGRAM, 8'h87, 10'd1, 2'd3, 2'd2, HOLD_CHIP},
        '{HOP_READ,    8'h98, 10'd1, 2'd0, 2'd2, HOLD_CHIP},
        '{HOP_PROGRAM, 8'hA9, 10'd2, 2'd2, 2'd0, HOLD_RSLT}
    };

    logic        i_clk;
    logic        i_rst = 1'b1;
    cmd_word_t   i_cmd_fifo_data = '0;
    logic        i_cmd_fifo_empty = 1'b1;
    data_word_t  i_wr_fifo_data = '0;
    fifo_count_t i_wr_fifo_count = '0;
    fifo_count_t i_rd_fifo_count = '0;
    logic        i_rslt_fifo_full = 1'b0;
    bus_mask_t   i_bus_cmd_ack = '0;
    bus_mask_t   i_bus_rsp_req = '0;
    rslt_word_t  i_bus_rsp_data = '0;
    chip_mask_t  i_bus_chip_active = '0;
    bus_mask_t   i_bus_wr_buffer_rsvd = '0;
    bus_mask_t   i_bus_rd_buffer_rsvd = '0;
    data_word_t  i_bus_rd_buffer_data = '0;
    logic        o_cmd_fifo_re, o_wr_fifo_re, o_rd_fifo_we, o_rslt_fifo_we;
    data_word_t  o_rd_fifo_data, o_bus_wr_buffer_data;
    rslt_word_t  o_rslt_fifo_data;
    bus_mask_t   o_bus_cmd_req, o_bus_rsp_ack, o_bus_rsp_listening, o_bus_wr_buffer_we;
    cmd_word_t   o_bus_cmd_data;
    buf_addr_t   o_bus_wr_buffer_addr, o_bus_rd_buffer_addr;

    // Test control and model state
    row_t        cur = '0;
    logic        start = 1'b0;
    chip_mask_t  chip_hold = '0;
    int          row_num = 0;
    int          done_cnt = 0;
    cmd_word_t   cmdq [$];
    data_word_t  wrq [$];
    data_word_t  wr_exp [$];
    int          ack_cnt [NUM_BUSES] = '{default: 0};
    int          rsp_cnt [NUM_BUSES] = '{default: 0};
    logic [1:0]  busy_chip [NUM_BUSES] = '{default: 2'd0};
    chip_mask_t  chip_busy = '0;
    data_word_t  rd_pipe = '0;
    int          wr_words = 0;
    int          rd_words = 0;
    int          reqs = 0;
    int          row_errs = 0;
    int          errs = 0;
    int          fails = 0;

    flash_bus_dispatch dut_i (.*);

    function automatic cmd_word_t pack_command(row_t r);
        // Spare address bits set so a decode off by two bits shows up
        return {r.tag, r.size, r.op, r.bus, 2'b10, r.chip, 32'h0ABC_0000, r.tag};
    endfunction

    function automatic data_word_t rd_pattern(int bus, int a);
        return {4{8'hA0 + 8'(bus), 12'h5C3, 2'b00, 10'(a)}};
    endfunction

    function automatic int bus_index(bus_mask_t m);
        for (int i = 0; i < NUM_BUSES; i++) begin
            if (m[i]) return i;
        end
        return 0;
    endfunction

    task automatic show_mismatch(string name, data_word_t got, data_word_t exp);
        $display("Error: row %0d %s = %0h, expected %0h", row_num, name, got, exp);
        row_errs++;
    endtask

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    initial begin
        repeat (NUM_ROWS * 400) @(posedge i_clk);
        $display("Timeout after %0d cycles with %0d rows done", NUM_ROWS * 400, done_cnt);
        $display("Testbench failed");
        $finish;
    end

    // FIFO, bus and read buffer models plus the checks
    always @(posedge i_clk) begin
        int b;
        data_word_t w;
        if (!i_rst) begin
            if (o_cmd_fifo_re && cmdq.size() > 0) void'(cmdq.pop_front());
            if (o_wr_fifo_re) begin
                if (wrq.size() > 0) begin
                    i_wr_fifo_data <= wrq.pop_front();
                end else begin
                    $display("Row %0d read the write FIFO while it was empty", row_num);
                    row_errs++;
                end
            end
            if (start) begin
                cmdq.push_back(pack_command(cur));
                for (int k = 0; cur.op == HOP_PROGRAM && k < 2 * int'(cur.size); k++) begin
                    w = {$urandom, $urandom, $urandom, $urandom};
                    wrq.push_back(w);
                    wr_exp.push_back(w);
                end
            end
            i_cmd_fifo_empty <= (cmdq.size() == 0);
            if (cmdq.size() > 0) i_cmd_fifo_data <= cmdq[0];
            i_wr_fifo_count <= fifo_count_t'(wrq.size());

            for (b = 0; b < NUM_BUSES; b++) begin
                i_bus_cmd_ack[b] <= 1'b0;
                if (o_bus_rsp_ack[b]) begin
                    i_bus_rsp_req[b] <= 1'b0;
                    chip_busy[b * CHIPS_PER_BUS + int'(busy_chip[b])] = 1'b0;
                end
                if (rsp_cnt[b] > 0) begin
                    rsp_cnt[b]--;
                    if (rsp_cnt[b] == 0) begin
                        i_bus_rsp_req[b] <= 1'b1;
                        i_bus_rsp_data   <= {cur.tag, cur.size, cur.tag};
                    end
                end
                if (o_bus_cmd_req[b] && !i_bus_cmd_ack[b] && ack_cnt[b] == 0) begin
                    ack_cnt[b] = int'($urandom_range(4, 1));
                end else if (ack_cnt[b] > 0) begin
                    ack_cnt[b]--;
                    if (ack_cnt[b] == 0) begin
                        i_bus_cmd_ack[b] <= 1'b1;
                        reqs++;
                        assert (o_bus_cmd_req == bus_mask_t'(1) << cur.bus) else
                            show_mismatch("o_bus_cmd_req", data_word_t'(o_bus_cmd_req),
                                          data_word_t'(bus_mask_t'(1) << cur.bus));
                        assert (o_bus_cmd_data == pack_command(cur)) else
                            show_mismatch("o_bus_cmd_data", data_word_t'(o_bus_cmd_data),
                                          data_word_t'(pack_command(cur)));
                        busy_chip[b] = cur.chip;
                        chip_busy[b * CHIPS_PER_BUS + int'(cur.chip)] = 1'b1;
                        rsp_cnt[b] = int'($urandom_range(20, 5));
                    end
                end
            end
            i_bus_chip_active <= chip_busy | chip_hold;

            // Two register stages give the 2-cycle read latency
            rd_pipe <= rd_pattern(bus_index(o_bus_rsp_listening), int'(o_bus_rd_buffer_addr));
            i_bus_rd_buffer_data <= rd_pipe;

            if (chip_hold != '0) begin
                assert (o_bus_cmd_req == '0) else begin
                    $display("Row %0d sent a request while its chip was held busy", row_num);
                    row_errs++;
                end
            end
            if (i_rslt_fifo_full) begin
                assert (!o_rslt_fifo_we) else begin
                    $display("Row %0d wrote a result while the result FIFO was full", row_num);
                    row_errs++;
                end
            end

            if (o_bus_wr_buffer_we != '0) begin
                assert (o_bus_wr_buffer_we == bus_mask_t'(1) << cur.bus) else
                    show_mismatch("o_bus_wr_buffer_we", data_word_t'(o_bus_wr_buffer_we),
                                  data_word_t'(bus_mask_t'(1) << cur.bus));
                assert (o_bus_wr_buffer_addr == buf_addr_t'(wr_words)) else
                    show_mismatch("o_bus_wr_buffer_addr", data_word_t'(o_bus_wr_buffer_addr),
                                  data_word_t'(wr_words));
                assert (o_bus_wr_buffer_data == wr_exp[wr_words]) else
                    show_mismatch("o_bus_wr_buffer_data", o_bus_wr_buffer_data, wr_exp[wr_words]);
                wr_words++;
            end

            if (o_rd_fifo_we) begin
                assert (o_rd_fifo_data == rd_pattern(int'(cur.bus), rd_words)) else
                    show_mismatch("o_rd_fifo_data", o_rd_fifo_data,
                                  rd_pattern(int'(cur.bus), rd_words));
                rd_words++;
            end

            if (o_rslt_fifo_we) begin
                assert (o_rslt_fifo_data == {cur.tag, cur.size, cur.tag}) else
                    show_mismatch("o_rslt_fifo_data", data_word_t'(o_rslt_fifo_data),
                                  data_word_t'({cur.tag, cur.size, cur.tag}));
                assert (rd_words == (cur.op == HOP_READ ? 2 * int'(cur.size) : 0)) else begin
                    $display("Row %0d got %0d read FIFO words", row_num, rd_words);
                    row_errs++;
                end
                assert (wr_words == wr_exp.size() && reqs == 1) else begin
                    $display("Row %0d wrote %0d buffer words and sent %0d requests",
                             row_num, wr_words, reqs);
                    row_errs++;
                end
                $display("Row %0d op %h tag %h size %0d bus %0d: %s", row_num, cur.op,
                         cur.tag, cur.size, cur.bus, row_errs == 0 ? "ok" : "FAILED");
                if (row_errs != 0) fails++;
                errs += row_errs;
                row_errs = 0;
                wr_words = 0;
                rd_words = 0;
                reqs     = 0;
                wr_exp.delete();
                done_cnt <= done_cnt + 1;
            end
        end
    end

    initial begin
        void'($urandom(39));
        repeat (8) @(posedge i_clk);
        i_rst <= 1'b0;
        repeat (4) @(posedge i_clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            cur     <= rows[i];
            row_num <= i;
            if (rows[i].hold == HOLD_CHIP) begin
                chip_hold <= chip_mask_t'(1) << (int'(rows[i].bus) * CHIPS_PER_BUS
                                                 + int'(rows[i].chip));
            end
            if (rows[i].hold == HOLD_RSLT) i_rslt_fifo_full <= 1'b1;
            @(posedge i_clk);
            start <= 1'b1;
            @(posedge i_clk);
            start <= 1'b0;
            if (rows[i].hold != HOLD_NONE) begin
                repeat (HOLD_CYCLES) @(posedge i_clk);
                chip_hold        <= '0;
                i_rslt_fifo_full <= 1'b0;
            end
            while (done_cnt != i + 1) @(posedge i_clk);
        end
        repeat (4) @(posedge i_clk);
        $display("Rows %0d, failed rows %0d, errors %0d", NUM_ROWS, fails, errs);
        if (errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
